//--- logic/fb_pkg.sv
/*
 * Shared constants of the memory front end
 * Bus widths, access size codes and the fetch size
 */
package fb_pkg;

   // Byte address width
   localparam int AW = 32;

   // Data word width
   localparam int DW = 32;

   // Instruction word, same as a data word
   localparam int IW = DW;

   // Width of the access size code
   localparam int SZ_W = 3;

   // Access size codes
   // Codes 3 to 7 decode as a full word
   localparam logic [SZ_W-1:0] SIZE_BYTE = 3'd0;
   localparam logic [SZ_W-1:0] SIZE_HALF = 3'd1;
   localparam logic [SZ_W-1:0] SIZE_WORD = 3'd2;

   // Fetches always move a whole word
   localparam logic [SZ_W-1:0] SIZE_INSN = SIZE_WORD;

endpackage

//--- logic/fb_byte_lane.sv
/*
 * Byte lane steering for the SRAM controller
 * Write strobes and lane placement, read extraction with zero extension
 */
module fb_byte_lane (
   input  logic [fb_pkg::AW-1:0]   addr,
   input  logic [fb_pkg::SZ_W-1:0] size,
   input  logic [fb_pkg::DW-1:0]   wdata,
   input  logic [fb_pkg::DW-1:0]   rword,
   output logic [3:0]              wstrb,
   output logic [fb_pkg::DW-1:0]   wword,
   output logic [fb_pkg::DW-1:0]   rdata
);

   logic [1:0]  ofs;
   logic [7:0]  rbyte;
   logic [15:0] rhalf;

   // Lane offset inside the word
   assign ofs = addr[1:0];

   // Addressed byte of the memory word
   always_comb begin
      case (ofs)
         2'd0:    rbyte = rword[7:0];
         2'd1:    rbyte = rword[15:8];
         2'd2:    rbyte = rword[23:16];
         default: rbyte = rword[31:24];
      endcase
   end

   // Halfword picked by addr[1] only
   assign rhalf = addr[1] ? rword[31:16] : rword[15:0];

   always_comb begin
      case (size)
         fb_pkg::SIZE_BYTE: begin
            // Replicate so any lane carries the byte
            wstrb = 4'b0001 << ofs;
            wword = {4{wdata[7:0]}};
            rdata = {{(fb_pkg::DW-8){1'b0}}, rbyte};
         end
         fb_pkg::SIZE_HALF: begin
            wstrb = addr[1] ? 4'b1100 : 4'b0011;
            wword = {2{wdata[15:0]}};
            rdata = {{(fb_pkg::DW-16){1'b0}}, rhalf};
         end
         fb_pkg::SIZE_WORD: begin
            wstrb = 4'b1111;
            wword = wdata;
            rdata = rword;
         end
         default: begin
            // Unused codes act as a word access
            wstrb = 4'b1111;
            wword = wdata;
            rdata = rword;
         end
      endcase
   end

endmodule

//--- logic/fb_order_fifo.sv
/*
 * Order queue of one-bit port tags
 * Circular buffer with read and write pointers and an occupancy count
 */
module fb_order_fifo #(
   parameter int ORDER_DEPTH_LOG2 = 2
) (
   input  logic clk,
   input  logic rst_n,
   input  logic push,
   input  logic push_tag,
   input  logic pop,
   output logic head_tag,
   output logic empty,
   output logic full
);

   localparam int DEPTH = 1 << ORDER_DEPTH_LOG2;

   // Tag storage, 1 marks a D-bus command
   logic tags [DEPTH];

   logic [ORDER_DEPTH_LOG2-1:0] wr_ptr;
   logic [ORDER_DEPTH_LOG2-1:0] rd_ptr;
   logic [ORDER_DEPTH_LOG2:0]   count;

   // Pointers and count
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Pointers wrap on their own width
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Tag written at the tail
   always_ff @(posedge clk) begin
      if (push)
         tags[wr_ptr] <= push_tag;
   end

   // Oldest outstanding command
   assign head_tag = tags[rd_ptr];

   assign empty = (count == '0);

   // Count MSB is set only at DEPTH entries
   assign full = count[ORDER_DEPTH_LOG2];

endmodule

//--- logic/fb_arbiter.sv
/*
 * Fixed-priority I-bus / D-bus arbiter onto the memory bus
 * D-bus wins, fetches forced to word reads
 * Responses steered in order by a queue of port tags
 */
module fb_arbiter #(
   parameter int ORDER_DEPTH_LOG2 = 2
) (
   input  logic                    clk,
   input  logic                    rst_n,
   // I-bus command
   input  logic                    ibus_cmd_valid,
   input  logic [fb_pkg::AW-1:0]   ibus_cmd_addr,
   output logic                    ibus_cmd_ready,
   // I-bus response
   output logic                    ibus_valid,
   output logic [fb_pkg::IW-1:0]   ibus_dout,
   input  logic                    ibus_ready,
   // D-bus command
   input  logic                    dbus_cmd_valid,
   input  logic [fb_pkg::AW-1:0]   dbus_cmd_addr,
   input  logic [fb_pkg::SZ_W-1:0] dbus_cmd_size,
   input  logic                    dbus_cmd_we,
   input  logic [fb_pkg::DW-1:0]   dbus_din,
   output logic                    dbus_cmd_ready,
   // D-bus response
   output logic                    dbus_valid,
   output logic [fb_pkg::DW-1:0]   dbus_dout,
   input  logic                    dbus_ready,
   // Memory bus command
   output logic                    mbus_cmd_valid,
   output logic [fb_pkg::AW-1:0]   mbus_cmd_addr,
   output logic [fb_pkg::SZ_W-1:0] mbus_cmd_size,
   output logic                    mbus_cmd_we,
   output logic [fb_pkg::DW-1:0]   mbus_din,
   input  logic                    mbus_cmd_ready,
   // Memory bus response
   input  logic                    mbus_valid,
   input  logic [fb_pkg::DW-1:0]   mbus_dout,
   output logic                    mbus_ready
);

   logic dbus_sel;
   logic q_push;
   logic q_pop;
   logic q_head;
   logic q_empty;
   logic q_full;
   logic dbus_rsp_sel;
   logic ibus_rsp_sel;

   // D-bus takes the slot whenever it asks
   assign dbus_sel = dbus_cmd_valid;

   // Hold off both ports while the tag queue is full
   assign mbus_cmd_valid = (dbus_cmd_valid | ibus_cmd_valid) & ~q_full;
   assign mbus_cmd_addr  = dbus_sel ? dbus_cmd_addr : ibus_cmd_addr;
   assign mbus_cmd_size  = dbus_sel ? dbus_cmd_size : fb_pkg::SIZE_INSN;
   assign mbus_cmd_we    = dbus_sel ? dbus_cmd_we : 1'b0;
   assign mbus_din       = dbus_din;

   // Ready only to the winner
   assign dbus_cmd_ready = dbus_sel & mbus_cmd_ready & ~q_full;
   assign ibus_cmd_ready = ~dbus_sel & mbus_cmd_ready & ~q_full;

   // Tag follows the memory handshake, head tag leaves with the response
   assign q_push = mbus_cmd_valid & mbus_cmd_ready;
   assign q_pop  = mbus_valid & mbus_ready;

   fb_order_fifo #(
      .ORDER_DEPTH_LOG2 (ORDER_DEPTH_LOG2)
   ) u_order_fifo (
      .clk      (clk),
      .rst_n    (rst_n),
      .push     (q_push),
      .push_tag (dbus_sel),
      .pop      (q_pop),
      .head_tag (q_head),
      .empty    (q_empty),
      .full     (q_full)
   );

   // Owner of the next response
   assign dbus_rsp_sel = ~q_empty & q_head;
   assign ibus_rsp_sel = ~q_empty & ~q_head;

   assign dbus_valid = dbus_rsp_sel & mbus_valid;
   assign ibus_valid = ibus_rsp_sel & mbus_valid;

   // Data zeroed on the idle port
   assign dbus_dout = {fb_pkg::DW{dbus_valid}} & mbus_dout;
   assign ibus_dout = {fb_pkg::IW{ibus_valid}} & mbus_dout;

   assign mbus_ready = (dbus_rsp_sel & dbus_ready) | (ibus_rsp_sel & ibus_ready);

endmodule

//--- logic/fb_sram_ctrl.sv
/*
 * Single-port SRAM controller
 * Word array with byte strobes, one-cycle read stage,
 * two-entry response buffer with back-pressure
 */
module fb_sram_ctrl #(
   parameter int MEM_WORDS_LOG2 = 8
) (
   input  logic                    clk,
   input  logic                    rst_n,
   // Command
   input  logic                    mbus_cmd_valid,
   input  logic [fb_pkg::AW-1:0]   mbus_cmd_addr,
   input  logic [fb_pkg::SZ_W-1:0] mbus_cmd_size,
   input  logic                    mbus_cmd_we,
   input  logic [fb_pkg::DW-1:0]   mbus_din,
   output logic                    mbus_cmd_ready,
   // Response
   output logic                    mbus_valid,
   output logic [fb_pkg::DW-1:0]   mbus_dout,
   input  logic                    mbus_ready
);

   localparam int MEM_WORDS = 1 << MEM_WORDS_LOG2;

   logic [fb_pkg::DW-1:0] mem [MEM_WORDS];

   logic                        cmd_hs;
   logic [MEM_WORDS_LOG2-1:0]   widx;
   logic [3:0]                  wstrb;
   logic [fb_pkg::DW-1:0]       wword;

   // Read stage
   logic                        s1_valid;
   logic [fb_pkg::DW-1:0]       s1_word;
   logic [fb_pkg::AW-1:0]       s1_addr;
   logic [fb_pkg::SZ_W-1:0]     s1_size;
   logic [fb_pkg::DW-1:0]       s1_data;

   // Response buffer
   logic [fb_pkg::DW-1:0]       rsp_data [2];
   logic                        rsp_wr;
   logic                        rsp_rd;
   logic [1:0]                  rsp_cnt;
   logic                        rsp_pop;

   assign cmd_hs  = mbus_cmd_valid & mbus_cmd_ready;
   assign rsp_pop = mbus_valid & mbus_ready;

   // Word index, byte offset dropped
   assign widx = mbus_cmd_addr[MEM_WORDS_LOG2+1:2];

   // Lane placement of the incoming command
   fb_byte_lane u_wr_lane (
      .addr  (mbus_cmd_addr),
      .size  (mbus_cmd_size),
      .wdata (mbus_din),
      .rword (mem[widx]),
      .wstrb (wstrb),
      .wword (wword),
      .rdata ()
   );

   // Byte writes under strobe
   always_ff @(posedge clk) begin
      if (cmd_hs && mbus_cmd_we) begin
         for (int b = 0; b < 4; b++) begin
            if (wstrb[b])
               mem[widx][b*8 +: 8] <= wword[b*8 +: 8];
         end
      end
   end

   // Read word captured at the handshake
   // Writes answer with zero data
   always_ff @(posedge clk) begin
      if (cmd_hs) begin
         s1_word <= mbus_cmd_we ? '0 : mem[widx];
         s1_addr <= mbus_cmd_addr;
         s1_size <= mbus_cmd_size;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         s1_valid <= 1'b0;
      else
         s1_valid <= cmd_hs;
   end

   // Extraction on the registered word
   fb_byte_lane u_rd_lane (
      .addr  (s1_addr),
      .size  (s1_size),
      .wdata ('0),
      .rword (s1_word),
      .wstrb (),
      .wword (),
      .rdata (s1_data)
   );

   // Slot is reserved at acceptance, so push never overflows
   always_ff @(posedge clk) begin
      if (s1_valid)
         rsp_data[rsp_wr] <= s1_data;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rsp_wr  <= 1'b0;
         rsp_rd  <= 1'b0;
         rsp_cnt <= 2'd0;
      end else begin
         if (s1_valid)
            rsp_wr <= ~rsp_wr;
         if (rsp_pop)
            rsp_rd <= ~rsp_rd;
         case ({s1_valid, rsp_pop})
            2'b10:   rsp_cnt <= rsp_cnt + 2'd1;
            2'b01:   rsp_cnt <= rsp_cnt - 2'd1;
            default: rsp_cnt <= rsp_cnt;
         endcase
      end
   end

   assign mbus_valid = (rsp_cnt != 2'd0);
   assign mbus_dout  = rsp_data[rsp_rd];

   // Buffered plus in-flight responses below two
   assign mbus_cmd_ready = (rsp_cnt == 2'd0) || ((rsp_cnt == 2'd1) && !s1_valid);

endmodule

//--- logic/fb_mem_top.sv
/*
 * Memory front end top level
 * Arbiter and SRAM controller joined by the memory bus
 */
module fb_mem_top #(
   parameter int MEM_WORDS_LOG2   = 8,
   parameter int ORDER_DEPTH_LOG2 = 2
) (
   input  logic                    clk,
   input  logic                    rst_n,
   // I-bus
   input  logic                    ibus_cmd_valid,
   input  logic [fb_pkg::AW-1:0]   ibus_cmd_addr,
   output logic                    ibus_cmd_ready,
   output logic                    ibus_valid,
   output logic [fb_pkg::IW-1:0]   ibus_dout,
   input  logic                    ibus_ready,
   // D-bus
   input  logic                    dbus_cmd_valid,
   input  logic [fb_pkg::AW-1:0]   dbus_cmd_addr,
   input  logic [fb_pkg::SZ_W-1:0] dbus_cmd_size,
   input  logic                    dbus_cmd_we,
   input  logic [fb_pkg::DW-1:0]   dbus_din,
   output logic                    dbus_cmd_ready,
   output logic                    dbus_valid,
   output logic [fb_pkg::DW-1:0]   dbus_dout,
   input  logic                    dbus_ready
);

   // Memory bus
   logic                    mbus_cmd_valid;
   logic [fb_pkg::AW-1:0]   mbus_cmd_addr;
   logic [fb_pkg::SZ_W-1:0] mbus_cmd_size;
   logic                    mbus_cmd_we;
   logic [fb_pkg::DW-1:0]   mbus_din;
   logic                    mbus_cmd_ready;
   logic                    mbus_valid;
   logic [fb_pkg::DW-1:0]   mbus_dout;
   logic                    mbus_ready;

   fb_arbiter #(
      .ORDER_DEPTH_LOG2 (ORDER_DEPTH_LOG2)
   ) u_arbiter (
      .clk            (clk),
      .rst_n          (rst_n),
      .ibus_cmd_valid (ibus_cmd_valid),
      .ibus_cmd_addr  (ibus_cmd_addr),
      .ibus_cmd_ready (ibus_cmd_ready),
      .ibus_valid     (ibus_valid),
      .ibus_dout      (ibus_dout),
      .ibus_ready     (ibus_ready),
      .dbus_cmd_valid (dbus_cmd_valid),
      .dbus_cmd_addr  (dbus_cmd_addr),
      .dbus_cmd_size  (dbus_cmd_size),
      .dbus_cmd_we    (dbus_cmd_we),
      .dbus_din       (dbus_din),
      .dbus_cmd_ready (dbus_cmd_ready),
      .dbus_valid     (dbus_valid),
      .dbus_dout      (dbus_dout),
      .dbus_ready     (dbus_ready),
      .mbus_cmd_valid (mbus_cmd_valid),
      .mbus_cmd_addr  (mbus_cmd_addr),
      .mbus_cmd_size  (mbus_cmd_size),
      .mbus_cmd_we    (mbus_cmd_we),
      .mbus_din       (mbus_din),
      .mbus_cmd_ready (mbus_cmd_ready),
      .mbus_valid     (mbus_valid),
      .mbus_dout      (mbus_dout),
      .mbus_ready     (mbus_ready)
   );

   fb_sram_ctrl #(
      .MEM_WORDS_LOG2 (MEM_WORDS_LOG2)
   ) u_sram_ctrl (
      .clk            (clk),
      .rst_n          (rst_n),
      .mbus_cmd_valid (mbus_cmd_valid),
      .mbus_cmd_addr  (mbus_cmd_addr),
      .mbus_cmd_size  (mbus_cmd_size),
      .mbus_cmd_we    (mbus_cmd_we),
      .mbus_din       (mbus_din),
      .mbus_cmd_ready (mbus_cmd_ready),
      .mbus_valid     (mbus_valid),
      .mbus_dout      (mbus_dout),
      .mbus_ready     (mbus_ready)
   );

endmodule

//--- dv/fb_arbiter_sva.sv
/*
 * Arbiter assertions, bound into fb_arbiter
 * Command ready and response valid exclusivity, D-bus priority
 */
module fb_arbiter_sva (
   input logic clk,
   input logic rst_n,
   input logic ibus_cmd_ready,
   input logic dbus_cmd_ready,
   input logic ibus_valid,
   input logic dbus_valid,
   input logic dbus_cmd_valid
);

   // Only one port is offered the command slot
   a_cmd_ready_excl: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(ibus_cmd_ready && dbus_cmd_ready)
   ) else $error("ibus_cmd_ready and dbus_cmd_ready high in the same cycle");

   // A response goes to one port only
   a_rsp_valid_excl: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(ibus_valid && dbus_valid)
   ) else $error("ibus_valid and dbus_valid high in the same cycle");

   // Pending D-bus command blocks the fetch port
   a_dbus_priority: assert property (
      @(posedge clk) disable iff (!rst_n)
      dbus_cmd_valid |-> !ibus_cmd_ready
   ) else $error("ibus_cmd_ready high while dbus_cmd_valid is high");

endmodule

bind fb_arbiter fb_arbiter_sva u_arbiter_sva (
   .clk            (clk),
   .rst_n          (rst_n),
   .ibus_cmd_ready (ibus_cmd_ready),
   .dbus_cmd_ready (dbus_cmd_ready),
   .ibus_valid     (ibus_valid),
   .dbus_valid     (dbus_valid),
   .dbus_cmd_valid (dbus_cmd_valid)
);

//--- dv/fb_tb.sv
/*
 * Testbench for the memory front end
 * Clock, reset, seeded random traffic on the I-bus and D-bus,
 * byte-array reference model and typed response checks
 */
module fb_tb;

   localparam int MEM_WORDS_LOG2   = 8;
   localparam int ORDER_DEPTH_LOG2 = 2;
   localparam int MEM_BYTES        = 4 << MEM_WORDS_LOG2;
   localparam int RAND_CYCLES      = 4000;
   localparam int STALL_LIMIT      = 200;
   localparam int DRAIN_LIMIT      = 500;

   logic                    clk;
   logic                    rst_n;
   logic                    ibus_cmd_valid;
   logic [fb_pkg::AW-1:0]   ibus_cmd_addr;
   logic                    ibus_cmd_ready;
   logic                    ibus_valid;
   logic [fb_pkg::IW-1:0]   ibus_dout;
   logic                    ibus_ready;
   logic                    dbus_cmd_valid;
   logic [fb_pkg::AW-1:0]   dbus_cmd_addr;
   logic [fb_pkg::SZ_W-1:0] dbus_cmd_size;
   logic                    dbus_cmd_we;
   logic [fb_pkg::DW-1:0]   dbus_din;
   logic                    dbus_cmd_ready;
   logic                    dbus_valid;
   logic [fb_pkg::DW-1:0]   dbus_dout;
   logic                    dbus_ready;

   // Reference memory, one entry per byte address
   logic [7:0] model_mem [MEM_BYTES];

   // Expected responses per port in issue order
   logic [fb_pkg::IW-1:0] exp_i [$];
   logic [fb_pkg::DW-1:0] exp_d [$];

   // Handshakes seen before the coming edge
   logic d_acc = 1'b0;
   logic i_acc = 1'b0;

   int cmds_seen = 0;
   int d_wait    = 0;
   int i_wait    = 0;
   int fill_addr = 0;
   int guard     = 0;

   fb_mem_top #(
      .MEM_WORDS_LOG2   (MEM_WORDS_LOG2),
      .ORDER_DEPTH_LOG2 (ORDER_DEPTH_LOG2)
   ) uut (
      .clk            (clk),
      .rst_n          (rst_n),
      .ibus_cmd_valid (ibus_cmd_valid),
      .ibus_cmd_addr  (ibus_cmd_addr),
      .ibus_cmd_ready (ibus_cmd_ready),
      .ibus_valid     (ibus_valid),
      .ibus_dout      (ibus_dout),
      .ibus_ready     (ibus_ready),
      .dbus_cmd_valid (dbus_cmd_valid),
      .dbus_cmd_addr  (dbus_cmd_addr),
      .dbus_cmd_size  (dbus_cmd_size),
      .dbus_cmd_we    (dbus_cmd_we),
      .dbus_din       (dbus_din),
      .dbus_cmd_ready (dbus_cmd_ready),
      .dbus_valid     (dbus_valid),
      .dbus_dout      (dbus_dout),
      .dbus_ready     (dbus_ready)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Verification failed");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_insn(input logic [fb_pkg::IW-1:0] got,
                             input logic [fb_pkg::IW-1:0] exp);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED at %0t: I-bus fetch got %h, expected %h",
                             $time, got, exp));
   endtask

   task automatic check_data(input logic [fb_pkg::DW-1:0] got,
                             input logic [fb_pkg::DW-1:0] exp);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED at %0t: D-bus response got %h, expected %h",
                             $time, got, exp));
   endtask

   // Little-endian read, low address bits below the size ignored
   function automatic logic [fb_pkg::DW-1:0] model_read(input logic [fb_pkg::AW-1:0] a,
                                                         input logic [fb_pkg::SZ_W-1:0] sz);
      int base;
      if (sz == fb_pkg::SIZE_BYTE)
         return {24'd0, model_mem[int'(a)]};
      if (sz == fb_pkg::SIZE_HALF) begin
         base = int'(a & ~32'd1);
         return {16'd0, model_mem[base+1], model_mem[base]};
      end
      // Word and the unused codes
      base = int'(a & ~32'd3);
      return {model_mem[base+3], model_mem[base+2], model_mem[base+1], model_mem[base]};
   endfunction

   function automatic void model_write(input logic [fb_pkg::AW-1:0] a,
                                       input logic [fb_pkg::SZ_W-1:0] sz,
                                       input logic [fb_pkg::DW-1:0] d);
      int base;
      if (sz == fb_pkg::SIZE_BYTE) begin
         model_mem[int'(a)] = d[7:0];
      end else if (sz == fb_pkg::SIZE_HALF) begin
         base = int'(a & ~32'd1);
         model_mem[base]   = d[7:0];
         model_mem[base+1] = d[15:8];
      end else begin
         base = int'(a & ~32'd3);
         for (int b = 0; b < 4; b++)
            model_mem[base+b] = d[b*8 +: 8];
      end
   endfunction

   // Monitor at the falling edge, where every signal is settled
   always @(negedge clk) begin
      d_acc = dbus_cmd_valid && dbus_cmd_ready;
      i_acc = ibus_cmd_valid && ibus_cmd_ready;
      if (!rst_n || cmds_seen == 0) begin
         if (ibus_valid || dbus_valid)
            abort_run("Response valid raised during reset or before any command");
      end
      if (rst_n) begin
         if (dbus_cmd_valid && ibus_cmd_ready)
            abort_run($sformatf("CHECK FAILED at %0t: ibus_cmd_ready high under D-bus request",
                                $time));
         // One port granted, one port answered
         if (ibus_cmd_ready && dbus_cmd_ready)
            abort_run($sformatf("CHECK FAILED at %0t: both command readies high",
                                $time));
         if (ibus_valid && dbus_valid)
            abort_run($sformatf("CHECK FAILED at %0t: both response valids high",
                                $time));
         // Responses first, so a spurious one cannot match a fresh entry
         if (dbus_valid && dbus_ready) begin
            if (exp_d.size() == 0)
               abort_run("D-bus response with no outstanding D-bus command");
            check_data(dbus_dout, exp_d.pop_front());
         end
         if (ibus_valid && ibus_ready) begin
            if (exp_i.size() == 0)
               abort_run("I-bus response with no outstanding fetch");
            check_insn(ibus_dout, exp_i.pop_front());
         end
         if (d_acc) begin
            cmds_seen++;
            if (dbus_cmd_we) begin
               model_write(dbus_cmd_addr, dbus_cmd_size, dbus_din);
               exp_d.push_back('0);
            end else begin
               exp_d.push_back(model_read(dbus_cmd_addr, dbus_cmd_size));
            end
         end
         if (i_acc) begin
            cmds_seen++;
            exp_i.push_back(model_read(ibus_cmd_addr, fb_pkg::SIZE_INSN));
         end
      end
   end

   // One clock of stimulus, inputs changed just after the edge
   task automatic drive_cycle(input bit fill, input bit issue);
      @(posedge clk);
      #1;
      ibus_ready = ($urandom_range(0, 3) != 0);
      dbus_ready = ($urandom_range(0, 3) != 0);
      // Retire commands taken at this edge
      if (dbus_cmd_valid && d_acc)
         dbus_cmd_valid = 1'b0;
      if (ibus_cmd_valid && i_acc)
         ibus_cmd_valid = 1'b0;
      d_wait = dbus_cmd_valid ? d_wait + 1 : 0;
      i_wait = ibus_cmd_valid ? i_wait + 1 : 0;
      if (d_wait > STALL_LIMIT)
         abort_run("Timeout: D-bus command was never accepted");
      if (i_wait > STALL_LIMIT)
         abort_run("Timeout: I-bus fetch was never accepted");
      if (!dbus_cmd_valid && issue) begin
         if (fill && fill_addr < MEM_BYTES) begin
            dbus_cmd_valid = 1'b1;
            dbus_cmd_addr  = fill_addr;
            dbus_cmd_size  = fb_pkg::SIZE_WORD;
            dbus_cmd_we    = 1'b1;
            dbus_din       = $urandom;
            fill_addr      = fill_addr + 4;
         end else if (!fill && $urandom_range(0, 2) == 0) begin
            // Size code 3 exercises the unused codes
            dbus_cmd_valid = 1'b1;
            dbus_cmd_addr  = $urandom_range(0, MEM_BYTES - 1);
            dbus_cmd_size  = $urandom_range(0, 3);
            dbus_cmd_we    = $urandom_range(0, 1);
            dbus_din       = $urandom;
         end
      end
      // Fetches only once every word holds data
      if (!ibus_cmd_valid && issue && !fill && $urandom_range(0, 1) == 0) begin
         ibus_cmd_valid = 1'b1;
         ibus_cmd_addr  = $urandom_range(0, MEM_BYTES - 1);
      end
   endtask

   initial begin
      void'($urandom(72));
      rst_n          = 1'b0;
      ibus_cmd_valid = 1'b0;
      ibus_cmd_addr  = '0;
      ibus_ready     = 1'b0;
      dbus_cmd_valid = 1'b0;
      dbus_cmd_addr  = '0;
      dbus_cmd_size  = '0;
      dbus_cmd_we    = 1'b0;
      dbus_din       = '0;
      dbus_ready     = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Fill every word through the D-bus
      guard = 0;
      while (fill_addr < MEM_BYTES || dbus_cmd_valid) begin
         drive_cycle(1'b1, 1'b1);
         guard++;
         if (guard > MEM_BYTES * 4)
            abort_run("Timeout: memory fill through the D-bus did not complete");
      end

      // Mixed random traffic on both ports
      repeat (RAND_CYCLES)
         drive_cycle(1'b0, 1'b1);

      // Drain outstanding commands and responses
      guard = 0;
      while (ibus_cmd_valid || dbus_cmd_valid || exp_i.size() != 0 || exp_d.size() != 0) begin
         drive_cycle(1'b0, 1'b0);
         guard++;
         if (guard > DRAIN_LIMIT)
            abort_run("Timeout: responses still outstanding after the drain period");
      end

      if (exp_i.size() == 0 && exp_d.size() == 0 && cmds_seen > MEM_BYTES / 4) begin
         $display("Verification passed");
         $finish;
      end else begin
         abort_run("Run ended with missing responses or too few commands");
      end
   end

endmodule

//--- all.f
logic/fb_pkg.sv
logic/fb_byte_lane.sv
logic/fb_order_fifo.sv
logic/fb_arbiter.sv
logic/fb_sram_ctrl.sv
logic/fb_mem_top.sv
dv/fb_arbiter_sva.sv
dv/fb_tb.sv
